// File: test/alu_input.txt
# name opcode sel en flush src1 src2 result zero less (all hex)
# zero and less: 0 or 1 is checked, 2 is not checked
add_basic 00 0 0 0 0000000000000005 0000000000000007 000000000000000c 0 2
add_wrap 00 0 0 0 ffffffffffffffff 0000000000000001 0000000000000000 1 2
sub_zero 08 0 0 0 123456789abcdef0 123456789abcdef0 0000000000000000 1 0
sub_small 08 0 0 0 0000000000000003 0000000000000005 fffffffffffffffe 0 1
addw_sext 10 0 0 0 000000007fffffff 0000000000000001 ffffffff80000000 0 2
addw_trunc 10 0 0 0 0000000100000005 0000000000000003 0000000000000008 0 2
slt_neg 02 0 0 0 ffffffffffffffff 0000000000000001 0000000000000001 0 1
sltu_neg 0a 0 0 0 ffffffffffffffff 0000000000000001 0000000000000000 0 0
slt_pos 02 0 0 0 0000000000000001 ffffffffffffffff 0000000000000000 0 0
sltu_pos 0a 0 0 0 0000000000000001 ffffffffffffffff 0000000000000001 0 1
slt_min 02 0 0 0 8000000000000000 7fffffffffffffff 0000000000000001 0 1
sltu_min 0a 0 0 0 8000000000000000 7fffffffffffffff 0000000000000000 0 0
slt_eq 02 0 0 0 0000000000000005 0000000000000005 0000000000000000 1 0
sltu_eq 0a 0 0 0 0000000000000005 0000000000000005 0000000000000000 1 0
sll_0 01 0 0 0 8000000000000081 0000000000000000 8000000000000081 2 2
sll_1 01 0 0 0 8000000000000081 0000000000000001 0000000000000102 2 2
sll_31 01 0 0 0 8000000000000081 000000000000001f 0000004080000000 2 2
sll_32 01 0 0 0 8000000000000081 0000000000000020 0000008100000000 2 2
sll_63 01 0 0 0 8000000000000081 000000000000003f 8000000000000000 2 2
srl_0 05 0 0 0 8000000000000081 0000000000000000 8000000000000081 2 2
srl_1 05 0 0 0 8000000000000081 0000000000000001 4000000000000040 2 2
srl_31 05 0 0 0 8000000000000081 000000000000001f 0000000100000000 2 2
srl_32 05 0 0 0 8000000000000081 0000000000000020 0000000080000000 2 2
srl_63 05 0 0 0 8000000000000081 000000000000003f 0000000000000001 2 2
sra_0 0d 0 0 0 8000000000000081 0000000000000000 8000000000000081 2 2
sra_1 0d 0 0 0 8000000000000081 0000000000000001 c000000000000040 2 2
sra_31 0d 0 0 0 8000000000000081 000000000000001f ffffffff00000000 2 2
sra_32 0d 0 0 0 8000000000000081 0000000000000020 ffffffff80000000 2 2
sra_63 0d 0 0 0 8000000000000081 000000000000003f ffffffffffffffff 2 2
srlw_0 15 0 0 0 ffffffff80000010 0000000000000000 ffffffff80000010 2 2
srlw_4 15 0 0 0 ffffffff80000010 0000000000000004 0000000008000001 2 2
srlw_36 15 0 0 0 ffffffff80000010 0000000000000024 0000000008000001 2 2
srlw_31 15 0 0 0 ffffffff80000010 000000000000001f 0000000000000001 2 2
sraw_4 1d 0 0 0 ffffffff80000010 0000000000000004 fffffffff8000001 2 2
sraw_31 1d 0 0 0 0000000080000010 000000000000001f ffffffffffffffff 2 2
pass_src2 03 0 0 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 ff00ff00ff00ff00 2 2
xor_mix 04 0 0 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 0ff00ff00ff00ff0 2 2
or_mix 06 0 0 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 fff0fff0fff0fff0 2 2
and_mix 07 0 0 0 f0f0f0f0f0f0f0f0 ff00ff00ff00ff00 f000f000f000f000 2 2
# multiplier, sel 0 mul, 1 mulh, 2 mulhsu, 3 mulhu
mul_neg3x5 00 0 1 0 fffffffffffffffd 0000000000000005 fffffffffffffff1 2 2
mulh_neg3x5 00 1 1 0 fffffffffffffffd 0000000000000005 ffffffffffffffff 2 2
mulhsu_neg3x5 00 2 1 0 fffffffffffffffd 0000000000000005 ffffffffffffffff 2 2
mulhu_neg3x5 00 3 1 0 fffffffffffffffd 0000000000000005 0000000000000004 2 2
mul_5xneg3 00 0 1 0 0000000000000005 fffffffffffffffd fffffffffffffff1 2 2
mulh_5xneg3 00 1 1 0 0000000000000005 fffffffffffffffd ffffffffffffffff 2 2
mulhsu_5xneg3 00 2 1 0 0000000000000005 fffffffffffffffd 0000000000000004 2 2
mul_min 00 0 1 0 8000000000000000 8000000000000000 0000000000000000 2 2
mulh_min 00 1 1 0 8000000000000000 8000000000000000 4000000000000000 2 2
mulhsu_min 00 2 1 0 8000000000000000 8000000000000000 c000000000000000 2 2
mulhu_min 00 3 1 0 8000000000000000 8000000000000000 4000000000000000 2 2
# divider, sel 4 div, 5 divu, 6 rem, 7 remu
div_neg20 00 4 1 0 ffffffffffffffec 0000000000000003 fffffffffffffffa 2 2
divu_neg20 00 5 1 0 ffffffffffffffec 0000000000000003 555555555555554e 2 2
rem_neg20 00 6 1 0 ffffffffffffffec 0000000000000003 fffffffffffffffe 2 2
remu_neg20 00 7 1 0 ffffffffffffffec 0000000000000003 0000000000000002 2 2
div_by0 00 4 1 0 0000000000000007 0000000000000000 ffffffffffffffff 2 2
divu_by0 00 5 1 0 0000000000000007 0000000000000000 ffffffffffffffff 2 2
rem_by0 00 6 1 0 0000000000000007 0000000000000000 0000000000000007 2 2
remu_by0 00 7 1 0 0000000000000007 0000000000000000 0000000000000007 2 2
div_ovf 00 4 1 0 8000000000000000 ffffffffffffffff 8000000000000000 2 2
rem_ovf 00 6 1 0 8000000000000000 ffffffffffffffff 0000000000000000 2 2
divu_big 00 5 1 0 8000000000000000 ffffffffffffffff 0000000000000000 2 2
remu_big 00 7 1 0 8000000000000000 ffffffffffffffff 8000000000000000 2 2
div_flush 00 4 1 1 0000000000000064 0000000000000007 000000000000000e 2 2

// File: alu.f
+incdir+rtl
rtl/alu_pkg.sv
rtl/mdu_pkg.sv
rtl/alu_shifter.sv
rtl/mdu_mul.sv
rtl/mdu_div.sv
rtl/alu.sv
test/alu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f alu.f --top-module alu_tb -o alu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/alu_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation reported failures"
  exit 1
fi

if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi

exit 0

// File: test/alu_tb.sv
module alu_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD = 20;
  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_COUNT = 16;
  localparam int HOLD_CYCLES = 3;
  localparam int FLUSH_AFTER = 10;

  logic        clk;
  logic        rst_n;
  logic [4:0]  alu_op;
  logic [63:0] src1;
  logic [63:0] src2;
  logic        mdu_en;
  logic [2:0]  mdu_sel;
  logic        flush;
  logic [63:0] result;
  logic        less;
  logic        zero;
  logic        stall;

  // one entry per vector with file lines ahead of random ones
  string       name_q[$];
  logic [4:0]  op_q[$];
  logic [2:0]  sel_q[$];
  logic        en_q[$];
  logic        flush_q[$];
  logic [63:0] a_q[$];
  logic [63:0] b_q[$];
  logic [63:0] res_q[$];
  logic [3:0]  zero_q[$];
  logic [3:0]  less_q[$];

  int          errors;
  int          cycles;
  int          cycle_limit;
  logic [31:0] rng_state;

  alu dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .alu_op_i  (alu_op),
    .src1_i    (src1),
    .src2_i    (src2),
    .mdu_en_i  (mdu_en),
    .mdu_sel_i (mdu_sel),
    .flush_i   (flush),
    .result_o  (result),
    .less_o    (less),
    .zero_o    (zero),
    .stall_o   (stall)
  );

  always #HALF_PERIOD clk = ~clk;

  // run length guard
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout, the run went past %0d cycles without finishing", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] v;
    v = x;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic logic [63:0] next_word();
    logic [31:0] hi;
    rng_state = xorshift32(rng_state);
    hi = rng_state;
    rng_state = xorshift32(rng_state);
    return {hi, rng_state};
  endfunction

  task automatic compare_word(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // flag value 2 in the file means not checked
  task automatic compare_flag(input string name, input logic [3:0] exp, input logic act);
    if (exp != 4'd2 && act !== exp[0]) begin
      $display("FAIL %s expected %0d actual %0d", name, exp[0], act);
      errors++;
    end
  endtask

  task automatic expect_stall(input string name, input logic level);
    if (stall !== level) begin
      $display("FAIL %s stall expected %0d actual %0d", name, level, stall);
      errors++;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          code;
    string       line;
    string       name;
    logic [4:0]  op;
    logic [2:0]  sel;
    logic        en;
    logic        fl;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [3:0]  ez;
    logic [3:0]  el;
    fd = $fopen("test/alu_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file test/alu_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 1 && line[0] != "#") begin
          code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                         name, op, sel, en, fl, a, b, r, ez, el);
          if (code == 10) begin
            name_q.push_back(name);
            op_q.push_back(op);
            sel_q.push_back(sel);
            en_q.push_back(en);
            flush_q.push_back(fl);
            a_q.push_back(a);
            b_q.push_back(b);
            res_q.push_back(r);
            zero_q.push_back(ez);
            less_q.push_back(el);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // random add, xor and shifts with expected values from the ISA rules
  task automatic add_random_vectors();
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] r;
    logic [4:0]  op;
    logic [3:0]  ez;
    int          kind;
    for (int i = 0; i < RANDOM_COUNT; i++) begin
      a = next_word();
      b = next_word();
      kind = i % 5;
      ez = 4'd2;
      case (kind)
        0: begin
          op = 5'h00;
          r = a + b;
          ez = (r == 64'd0) ? 4'd1 : 4'd0;
        end
        1: begin
          op = 5'h04;
          r = a ^ b;
        end
        2: begin
          op = 5'h01;
          r = a << b[5:0];
        end
        3: begin
          op = 5'h05;
          r = a >> b[5:0];
        end
        default: begin
          op = 5'h0d;
          r = $signed(a) >>> b[5:0];
        end
      endcase
      name_q.push_back($sformatf("rand_%0d", i));
      op_q.push_back(op);
      sel_q.push_back(3'd0);
      en_q.push_back(1'b0);
      flush_q.push_back(1'b0);
      a_q.push_back(a);
      b_q.push_back(b);
      res_q.push_back(r);
      zero_q.push_back(ez);
      less_q.push_back(4'd2);
    end
  endtask

  task automatic wait_stall_low();
    while (stall) begin
      @(negedge clk);
    end
  endtask

  task automatic run_vector(input int idx);
    string       name;
    name = name_q[idx];
    @(negedge clk);
    alu_op  = op_q[idx];
    mdu_sel = sel_q[idx];
    mdu_en  = en_q[idx];
    src1    = a_q[idx];
    src2    = b_q[idx];
    flush   = 1'b0;
    #(HALF_PERIOD / 2);
    if (!en_q[idx]) begin
      compare_word(name, res_q[idx], result);
      compare_flag(name, zero_q[idx], zero);
      compare_flag(name, less_q[idx], less);
    end else begin
      expect_stall(name, 1'b1);
      if (flush_q[idx]) begin
        // abort mid-operation and expect a fresh launch
        repeat (FLUSH_AFTER) @(negedge clk);
        flush = 1'b1;
        #(HALF_PERIOD / 2);
        expect_stall(name, 1'b0);
        @(negedge clk);
        flush = 1'b0;
        #(HALF_PERIOD / 2);
        expect_stall(name, 1'b1);
      end
      @(negedge clk);
      wait_stall_low();
      // done cycle shows the live MDU result
      compare_word(name, res_q[idx], result);
      // operands stay put so no relaunch is expected
      repeat (HOLD_CYCLES) begin
        @(negedge clk);
        expect_stall(name, 1'b0);
        compare_word(name, res_q[idx], result);
      end
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    alu_op      = 5'h00;
    src1        = 64'd0;
    src2        = 64'd0;
    mdu_en      = 1'b0;
    mdu_sel     = 3'd0;
    flush       = 1'b0;
    errors      = 0;
    cycles      = 0;
    cycle_limit = 0;
    rng_state   = 32'h9bab_bcd7;

    load_vectors();
    add_random_vectors();
    cycle_limit = name_q.size() * 80 + 100;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < name_q.size(); i++) begin
      run_vector(i);
    end

    @(negedge clk);
    mdu_en = 1'b0;
    $display("vectors: %0d  errors: %0d", name_q.size(), errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: rtl/alu.sv
`include "alu_consts.svh"

module alu (
  input  logic              clk,
  input  logic              rst_n,
  input  alu_pkg::alu_op_t  alu_op_i,
  input  alu_pkg::xlen_t    src1_i,
  input  alu_pkg::xlen_t    src2_i,
  input  logic              mdu_en_i,
  input  mdu_pkg::mdu_sel_t mdu_sel_i,
  input  logic              flush_i,
  output alu_pkg::xlen_t    result_o,
  output logic              less_o,
  output logic              zero_o,
  output logic              stall_o
);

  import alu_pkg::*;
  import mdu_pkg::*;

  logic [`ALU_OP_MUX_MSB:0] mux_sel;
  logic                     word;
  logic                     variant;
  logic                     sub;
  logic                     shift_right;
  xlen_t                    add_b;
  xlen_t                    sum;
  logic                     carry;
  logic                     overflow;
  xlen_t                    shift_res;
  xlen_t                    mux_res;
  xlen_t                    alu_res;
  xlen_t                    src1_q;
  xlen_t                    src2_q;
  mdu_sel_t                 sel_q;
  logic                     lock_valid;
  logic                     busy_q;
  logic                     diff_in;
  logic                     start;
  logic                     mul_start;
  logic                     div_start;
  logic                     mul_done;
  logic                     div_done;
  logic                     mdu_done;
  xlen_t                    mul_res;
  xlen_t                    div_res;
  xlen_t                    mdu_live;
  xlen_t                    mdu_res_q;
  xlen_t                    mdu_out;

  // opcode decode
  assign mux_sel     = alu_op_i[`ALU_OP_MUX_MSB:0];
  assign word        = alu_op_i[`ALU_OP_WORD];
  assign variant     = alu_op_i[`ALU_OP_VAR];
  assign sub         = variant | (mux_sel == `ALU_MUX_SLT);
  assign shift_right = (mux_sel == `ALU_MUX_SRL);

  // adder, subtract by inverting src2 and carrying in
  assign add_b          = src2_i ^ {`ALU_XLEN{sub}};
  assign {carry, sum}   = {1'b0, src1_i} + {1'b0, add_b} + {{`ALU_XLEN{1'b0}}, sub};
  assign overflow       = (src1_i[`ALU_XLEN-1] == add_b[`ALU_XLEN-1]) &&
                          (sum[`ALU_XLEN-1] != src1_i[`ALU_XLEN-1]);
  assign zero_o         = ~|sum;
  // no carry out of a - b means a < b unsigned
  assign less_o         = variant ? ~carry : sum[`ALU_XLEN-1] ^ overflow;

  alu_shifter u_shifter (
    .word_i  (word),
    .src_i   (src1_i),
    .shamt_i (src2_i[`ALU_SHAMT_W-1:0]),
    .right_i (shift_right),
    .arith_i (variant),
    .shift_o (shift_res)
  );

  always_comb begin
    case (mux_sel)
      `ALU_MUX_ADD:  mux_res = sum;
      `ALU_MUX_SLL:  mux_res = shift_res;
      `ALU_MUX_SLT:  mux_res = {{(`ALU_XLEN-1){1'b0}}, less_o};
      `ALU_MUX_SRC2: mux_res = src2_i;
      `ALU_MUX_XOR:  mux_res = src1_i ^ src2_i;
      `ALU_MUX_SRL:  mux_res = shift_res;
      `ALU_MUX_OR:   mux_res = src1_i | src2_i;
      `ALU_MUX_AND:  mux_res = src1_i & src2_i;
    endcase
  end

  // launch once per distinct operand set so start stays a single pulse
  assign diff_in   = !lock_valid || (src1_i != src1_q) || (src2_i != src2_q) ||
                     (mdu_sel_i != sel_q);
  assign start     = mdu_en_i & diff_in & ~flush_i;
  assign mul_start = start & ~mdu_sel_i[`MDU_SEL_DIV];
  assign div_start = start & mdu_sel_i[`MDU_SEL_DIV];

  always_ff @(posedge clk) begin
    if (start) begin
      src1_q <= src1_i;
      src2_q <= src2_i;
      sel_q  <= mdu_sel_i;
    end
    if (mdu_done) begin
      mdu_res_q <= mdu_live;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lock_valid <= 1'b0;
      busy_q     <= 1'b0;
    end else if (flush_i) begin
      lock_valid <= 1'b0;
      busy_q     <= 1'b0;
    end else if (start) begin
      lock_valid <= 1'b1;
      busy_q     <= 1'b1;
    end else if (mdu_done) begin
      busy_q <= 1'b0;
    end
  end

  mdu_mul u_mul (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (mul_start),
    .flush_i        (flush_i),
    .type_i         (mdu_sel_i[`MDU_SEL_DIV-1:0]),
    .multiplicand_i (src1_i),
    .multiplier_i   (src2_i),
    .done_o         (mul_done),
    .result_o       (mul_res)
  );

  mdu_div u_div (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (div_start),
    .flush_i    (flush_i),
    .type_i     (mdu_sel_i[`MDU_SEL_DIV-1:0]),
    .dividend_i (src1_i),
    .divisor_i  (src2_i),
    .done_o     (div_done),
    .result_o   (div_res)
  );

  assign mdu_done = mul_done | div_done;
  assign mdu_live = sel_q[`MDU_SEL_DIV] ? div_res : mul_res;
  assign mdu_out  = mdu_done ? mdu_live : mdu_res_q;

  // stall covers the start cycle and drops as done pulses
  assign stall_o = start | (busy_q & ~mdu_done & ~flush_i);

  assign alu_res  = mdu_en_i ? mdu_out : mux_res;
  assign result_o = word ?
                    {{(`ALU_XLEN-`ALU_WLEN){alu_res[`ALU_WLEN-1]}}, alu_res[`ALU_WLEN-1:0]} :
                    alu_res;

  // stall only opens with a launch
  assert property (@(posedge clk) disable iff (!rst_n) $rose(stall_o) |-> start);

  // no relaunch while an MDU op is still in flight
  assert property (@(posedge clk) disable iff (!rst_n) start |-> (!busy_q || mdu_done));

endmodule

// File: rtl/mdu_div.sv
`include "alu_consts.svh"

module mdu_div (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  logic                  flush_i,
  input  logic [`MDU_SEL_W-2:0] type_i,
  input  alu_pkg::xlen_t        dividend_i,
  input  alu_pkg::xlen_t        divisor_i,
  output logic                  done_o,
  output alu_pkg::xlen_t        result_o
);

  import alu_pkg::*;
  import mdu_pkg::*;

  div_state_t              state;
  logic [`ALU_SHAMT_W-1:0] cnt;
  xlen_t                   rem;
  xlen_t                   quo;
  xlen_t                   dvs;
  xlen_t                   cur_rem;
  xlen_t                   cur_quo;
  xlen_t                   cur_dvs;
  logic [`ALU_XLEN:0]      rem_sh;
  logic [`ALU_XLEN+1:0]    diff;
  logic                    fits;
  xlen_t                   quo_fix;
  xlen_t                   rem_fix;
  xlen_t                   abs_a;
  xlen_t                   abs_b;
  logic                    is_signed;
  logic                    is_rem;
  logic                    neg_a;
  logic                    neg_b;
  logic                    neg_q_q;
  logic                    neg_r_q;
  logic                    zero_q;
  logic                    rem_q;
  logic                    load;
  logic                    last;

  always_comb begin
    case (type_i)
      `MDU_DIV: begin
        is_signed = 1'b1;
        is_rem    = 1'b0;
      end
      `MDU_DIVU: begin
        is_signed = 1'b0;
        is_rem    = 1'b0;
      end
      `MDU_REM: begin
        is_signed = 1'b1;
        is_rem    = 1'b1;
      end
      `MDU_REMU: begin
        is_signed = 1'b0;
        is_rem    = 1'b1;
      end
    endcase
  end

  assign neg_a = is_signed & dividend_i[`ALU_XLEN-1];
  assign neg_b = is_signed & divisor_i[`ALU_XLEN-1];
  assign abs_a = neg_a ? -dividend_i : dividend_i;
  assign abs_b = neg_b ? -divisor_i : divisor_i;

  assign load = start_i & (state != DIV_RUN) & (state != DIV_FIX);
  assign last = (state == DIV_RUN) && (cnt == '1);

  // one restoring step, fed straight from the operands at load
  assign cur_rem = load ? '0 : rem;
  assign cur_quo = load ? abs_a : quo;
  assign cur_dvs = load ? abs_b : dvs;
  assign rem_sh  = {cur_rem, cur_quo[`ALU_XLEN-1]};
  assign diff    = {1'b0, rem_sh} - {2'b00, cur_dvs};
  assign fits    = ~diff[`ALU_XLEN+1];

  // zero divisor leaves the dividend in rem, only the quotient needs forcing
  // most-negative / -1 comes out right without a special case
  assign quo_fix = zero_q ? '1 : (neg_q_q ? -quo : quo);
  assign rem_fix = neg_r_q ? -rem : rem;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= DIV_IDLE;
      cnt    <= '0;
      done_o <= 1'b0;
    end else if (flush_i) begin
      state  <= DIV_IDLE;
      done_o <= 1'b0;
    end else begin
      done_o <= (state == DIV_FIX);
      if (load) begin
        state <= DIV_RUN;
        cnt   <= 'd1;
      end else if (state == DIV_RUN) begin
        cnt <= cnt + 1'b1;
        if (last) begin
          state <= DIV_FIX;
        end
      end else if (state == DIV_FIX) begin
        state <= DIV_DONE;
      end else begin
        state <= DIV_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load || state == DIV_RUN) begin
      rem <= fits ? diff[`ALU_XLEN-1:0] : rem_sh[`ALU_XLEN-1:0];
      quo <= {cur_quo[`ALU_XLEN-2:0], fits};
      dvs <= cur_dvs;
    end
    if (load) begin
      neg_q_q <= neg_a ^ neg_b;
      neg_r_q <= neg_a;
      zero_q  <= (divisor_i == '0);
      rem_q   <= is_rem;
    end
    if (state == DIV_FIX) begin
      result_o <= rem_q ? rem_fix : quo_fix;
    end
  end

  // a single pulse per division
  assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !done_o);

endmodule

// File: rtl/mdu_mul.sv
`include "alu_consts.svh"

module mdu_mul (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start_i,
  input  logic                  flush_i,
  input  logic [`MDU_SEL_W-2:0] type_i,
  input  alu_pkg::xlen_t        multiplicand_i,
  input  alu_pkg::xlen_t        multiplier_i,
  output logic                  done_o,
  output alu_pkg::xlen_t        result_o
);

  import alu_pkg::*;
  import mdu_pkg::*;

  localparam int PW = 2 * `ALU_XLEN;

  mul_state_t              state;
  logic [`ALU_SHAMT_W-1:0] cnt;
  logic [PW-1:0]           acc;
  logic [PW-1:0]           mcand;
  xlen_t                   mplier;
  logic [`MDU_SEL_W-2:0]   type_q;
  logic                    mplier_signed_q;
  logic                    mcand_signed;
  logic                    mplier_signed;
  logic                    load;
  logic                    last;
  logic [PW-1:0]           cur_acc;
  logic [PW-1:0]           cur_mcand;
  logic [PW-1:0]           addend;
  logic [PW-1:0]           step_acc;
  logic                    cur_bit;

  always_comb begin
    case (type_i)
      `MDU_MULH: begin
        mcand_signed  = 1'b1;
        mplier_signed = 1'b1;
      end
      `MDU_MULHSU: begin
        mcand_signed  = 1'b1;
        mplier_signed = 1'b0;
      end
      // low half is the same for any signedness
      `MDU_MUL, `MDU_MULHU: begin
        mcand_signed  = 1'b0;
        mplier_signed = 1'b0;
      end
    endcase
  end

  // the load cycle already does step 0
  assign load = start_i & (state != MUL_RUN);
  assign last = (state == MUL_RUN) && (cnt == '1);

  assign cur_acc   = load ? '0 : acc;
  assign cur_mcand = load ?
                     {{`ALU_XLEN{mcand_signed & multiplicand_i[`ALU_XLEN-1]}}, multiplicand_i} :
                     mcand;
  assign cur_bit   = load ? multiplier_i[0] : mplier[0];
  assign addend    = cur_bit ? cur_mcand : '0;

  // bit 63 of a signed multiplier weighs -2^63
  assign step_acc = (last && mplier_signed_q) ? cur_acc - addend : cur_acc + addend;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= MUL_IDLE;
      cnt    <= '0;
      done_o <= 1'b0;
    end else if (flush_i) begin
      state  <= MUL_IDLE;
      done_o <= 1'b0;
    end else begin
      done_o <= last;
      if (load) begin
        state <= MUL_RUN;
        cnt   <= 'd1;
      end else if (state == MUL_RUN) begin
        cnt <= cnt + 1'b1;
        if (last) begin
          state <= MUL_DONE;
        end
      end else begin
        state <= MUL_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load || state == MUL_RUN) begin
      acc    <= step_acc;
      mcand  <= cur_mcand << 1;
      mplier <= (load ? multiplier_i : mplier) >> 1;
    end
    if (load) begin
      type_q          <= type_i;
      mplier_signed_q <= mplier_signed;
    end
  end

  assign result_o = (type_q == `MDU_MUL) ? acc[`ALU_XLEN-1:0] : acc[PW-1:`ALU_XLEN];

  // done marks the cycle right after the last step
  assert property (@(posedge clk) disable iff (!rst_n)
    done_o |-> (state == MUL_DONE) && ($past(state) == MUL_RUN));

endmodule

// File: rtl/alu_shifter.sv
`include "alu_consts.svh"

module alu_shifter (
  input  logic            word_i,
  input  alu_pkg::xlen_t  src_i,
  input  alu_pkg::shamt_t shamt_i,
  input  logic            right_i,
  input  logic            arith_i,
  output alu_pkg::xlen_t  shift_o
);

  import alu_pkg::*;

  shamt_t amount;
  xlen_t  shift_in;
  xlen_t  shifted;
  xlen_t  mask_full;
  xlen_t  fill_mask;
  xlen_t  right_res;
  logic   fill_bit;

  function automatic xlen_t bit_rev(input xlen_t v);
    xlen_t r;
    for (int i = 0; i < `ALU_XLEN; i++) begin
      r[i] = v[`ALU_XLEN-1-i];
    end
    return r;
  endfunction

  // word forms only look at five shift bits
  assign amount = word_i ? {1'b0, shamt_i[`ALU_SHAMT_W-2:0]} : shamt_i;

  // left shifts go through the same right shifter, mirrored
  assign shift_in = right_i ? src_i : bit_rev(src_i);
  assign shifted  = shift_in >> amount;

  // ones where vacated bits land
  assign mask_full = ~({`ALU_XLEN{1'b1}} >> amount);

  // for words the vacated bits sit just below bit 31
  assign fill_mask = word_i ?
                     {{`ALU_WLEN{1'b0}}, mask_full[`ALU_XLEN-1:`ALU_WLEN]} :
                     mask_full;

  assign fill_bit = arith_i & (word_i ? src_i[`ALU_WLEN-1] : src_i[`ALU_XLEN-1]);

  // clear upper-half bits pulled into a word, then fill with sign
  assign right_res = (shifted & ~fill_mask) | ({`ALU_XLEN{fill_bit}} & fill_mask);

  assign shift_o = right_i ? right_res : bit_rev(shifted);

endmodule

// File: rtl/mdu_pkg.sv
`include "alu_consts.svh"

package mdu_pkg;

  // bit 2 picks the divider and bits 1:0 give the operation type
  typedef logic [`MDU_SEL_W-1:0] mdu_sel_t;

  // multiplier sequencing
  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_RUN,
    MUL_DONE
  } mul_state_t;

  // divider sequencing with a sign fix-up step
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_FIX,
    DIV_DONE
  } div_state_t;

endpackage

// File: rtl/alu_pkg.sv
`include "alu_consts.svh"

package alu_pkg;

  // operand or result word
  typedef logic [`ALU_XLEN-1:0] xlen_t;

  // opcode with word, variant and mux fields
  typedef logic [`ALU_OP_W-1:0] alu_op_t;

  // shift amount, wide enough for the 64-bit forms
  typedef logic [`ALU_SHAMT_W-1:0] shamt_t;

endpackage

// File: rtl/alu_consts.svh
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// data widths
`define ALU_XLEN     64
`define ALU_WLEN     32
`define ALU_SHAMT_W  6
`define ALU_OP_W     5
`define MDU_SEL_W    3

// opcode field positions
`define ALU_OP_WORD     4
`define ALU_OP_VAR      3
`define ALU_OP_MUX_MSB  2

// result mux codes in opcode bits 2:0
`define ALU_MUX_ADD   3'd0
`define ALU_MUX_SLL   3'd1
`define ALU_MUX_SLT   3'd2
`define ALU_MUX_SRC2  3'd3
`define ALU_MUX_XOR   3'd4
`define ALU_MUX_SRL   3'd5
`define ALU_MUX_OR    3'd6
`define ALU_MUX_AND   3'd7

// select bit that routes to the divider
`define MDU_SEL_DIV   2

// multiplier types in select bits 1:0
`define MDU_MUL     2'd0
`define MDU_MULH    2'd1
`define MDU_MULHSU  2'd2
`define MDU_MULHU   2'd3

// divider types in select bits 1:0
`define MDU_DIV     2'd0
`define MDU_DIVU    2'd1
`define MDU_REM     2'd2
`define MDU_REMU    2'd3

`endif
